// File: compile.f
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/rv32i_alu.sv
hdl/rv32i_regfile.sv
hdl/rv32i_mem.sv
hdl/rv32i_trap_csr.sv
hdl/rv32i_ctrl.sv
hdl/rv32i_core.sv
testbench/rv32i_core_tb.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= rv32i_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/rv32i_cases.txt
# Records: C new case | P byte_addr word | R raise run | E pc rd data | H ecall_pc
# Values in hex except rd (decimal). pc 0 holds a nop since run rises mid-cycle
# ALU register and immediate forms, LUI, AUIPC, x0 write
C
P 00 00000013 # nop
P 04 FFB00093 # addi x1, x0, -5
P 08 00300113 # addi x2, x0, 3
P 0C 0020A1B3 # slt x3, x1, x2
P 10 0020B233 # sltu x4, x1, x2
P 14 FFF13293 # sltiu x5, x2, -1
P 18 4010D313 # srai x6, x1, 1
P 1C 01C0D393 # srli x7, x1, 28
P 20 40110433 # sub x8, x2, x1
P 24 008114B3 # sll x9, x2, x8
P 28 0FF4C513 # xori x10, x9, 0xff
P 2C 00710013 # addi x0, x2, 7
P 30 123455B7 # lui x11, 0x12345
P 34 00001617 # auipc x12, 1
P 38 00A5E6B3 # or x13, x11, x10
P 3C 0016F733 # and x14, x13, x1
P 40 00000073 # ecall
R
E 04 1 FFFFFFFB
E 08 2 00000003
E 0C 3 00000001
E 10 4 00000000
E 14 5 00000001
E 18 6 FFFFFFFD
E 1C 7 0000000F
E 20 8 00000008
E 24 9 00000300
E 28 10 000003FF
E 30 11 12345000
E 34 12 00001034
E 38 13 123453FF
E 3C 14 123453FB
H 40
# Branches, JAL and JALR
C
P 00 00000013 # nop
P 04 00500093 # addi x1, x0, 5
P 08 FFF00113 # addi x2, x0, -1
P 0C 00208463 # beq x1, x2, +8 not taken
P 10 00114463 # blt x2, x1, +8 taken
P 14 00100193 # addi x3, x0, 1 skipped
P 18 00116463 # bltu x2, x1, +8 not taken
P 1C 00209463 # bne x1, x2, +8 taken
P 20 00200193 # addi x3, x0, 2 skipped
P 24 00C0026F # jal x4, +12
P 28 00300193 # addi x3, x0, 3 skipped
P 30 00700293 # addi x5, x0, 7
P 34 01420367 # jalr x6, 20(x4)
P 38 00400193 # addi x3, x0, 4 skipped
P 3C 0020D463 # bge x1, x2, +8 taken
P 40 00500193 # addi x3, x0, 5 skipped
P 44 0020F463 # bgeu x1, x2, +8 not taken
P 48 00900393 # addi x7, x0, 9
P 4C 00000073 # ecall
R
E 04 1 00000005
E 08 2 FFFFFFFF
E 24 4 00000028
E 30 5 00000007
E 34 6 00000038
E 48 7 00000009
H 4C
# Stores and loads with sign and zero extension
C
P 00 00000013 # nop
P 04 89ABC0B7 # lui x1, 0x89abc
P 08 7F008093 # addi x1, x1, 0x7f0
P 0C 10000113 # addi x2, x0, 0x100
P 10 00112023 # sw x1, 0(x2)
P 14 00012183 # lw x3, 0(x2)
P 18 00011203 # lh x4, 0(x2)
P 1C 00215283 # lhu x5, 2(x2)
P 20 00010303 # lb x6, 0(x2)
P 24 00114383 # lbu x7, 1(x2)
P 28 00012423 # sw x0, 8(x2)
P 2C 00111423 # sh x1, 8(x2)
P 30 00110523 # sb x1, 10(x2)
P 34 00812403 # lw x8, 8(x2)
P 38 00A10483 # lb x9, 10(x2)
P 3C 00000073 # ecall
R
E 04 1 89ABC000
E 08 1 89ABC7F0
E 0C 2 00000100
E 14 3 89ABC7F0
E 18 4 FFFFC7F0
E 1C 5 000089AB
E 20 6 FFFFFFF0
E 24 7 000000C7
E 34 8 00F0C7F0
E 38 9 FFFFFFF0
H 3C
# Illegal instruction trap, handler reads mepc and mcause, MRET
C
P 00 00000013 # nop
P 04 04000093 # addi x1, x0, 0x40
P 08 30509173 # csrrw x2, mtvec, x1
P 0C 00000000 # illegal, traps to 0x40
P 10 00100193 # addi x3, x0, 1
P 14 00000073 # ecall
P 40 34102273 # csrrs x4, mepc, x0
P 44 342022F3 # csrrs x5, mcause, x0
P 48 30200073 # mret
R
E 04 1 00000040
E 08 2 00000000
E 40 4 0000000C
E 44 5 00000002
E 10 3 00000001
H 14
# CSR instructions on mscratch
C
P 00 00000013 # nop
P 04 340020F3 # csrrs x1, mscratch, x0
P 08 0F000113 # addi x2, x0, 0xf0
P 0C 340111F3 # csrrw x3, mscratch, x2
P 10 03000293 # addi x5, x0, 0x30
P 14 3402B273 # csrrc x4, mscratch, x5
P 18 3402D373 # csrrwi x6, mscratch, 5
P 1C 340D63F3 # csrrsi x7, mscratch, 0x1a
P 20 34002473 # csrrs x8, mscratch, x0
P 24 00000073 # ecall
R
E 04 1 00001001
E 08 2 000000F0
E 0C 3 00001001
E 10 5 00000030
E 14 4 000000F0
E 18 6 000000C0
E 1C 7 00000005
E 20 8 0000001F
H 24
# Reset after a halt restarts the same program from pc 0
C
R
E 04 1 00001001
H 24

// File: testbench/rv32i_core_tb.sv
//========================================
// Testbench for the single-cycle RV32I core
// Loads programs and checks retires listed in rv32i_cases.txt
//========================================
module rv32i_core_tb;
    import rv32i_pkg::*;

    localparam int WAIT_LIMIT = 200;    // Cycles per wait loop

    logic       clk;
    logic       rst;
    logic       run;
    logic       prog_we;
    logic [7:0] prog_addr;
    word_t      prog_wdata;
    logic       halted;
    logic       retire_valid;
    word_t      retire_pc;
    logic       retire_we;
    reg_idx_t   retire_rd;
    word_t      retire_data;

    int error_count;
    int timeout_count;

    rv32i_core dut (
        .clk, .rst, .run, .prog_we, .prog_addr, .prog_wdata, .halted,
        .retire_valid, .retire_pc, .retire_we, .retire_rd, .retire_data
    );

    always #2 clk = ~clk;

    //========================================
    // Compare tasks
    //========================================
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got x%0d, expected x%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    //========================================
    // Stimulus and retire waits
    //========================================
    task automatic reset_core();
        @(negedge clk);
        rst     = 1'b1;
        run     = 1'b0;
        prog_we = 1'b0;
        repeat (4) @(negedge clk);
        check_flag("halted", halted, 1'b0);        // Reset state before release
        check_flag("retire_valid", retire_valid, 1'b0);
        check_word("retire_pc", retire_pc, 32'h0);
        rst = 1'b0;
    endtask

    task automatic load_word(input word_t byte_addr, input word_t data);
        @(negedge clk);
        prog_we    = 1'b1;
        prog_addr  = byte_addr[9:2];    // Word index
        prog_wdata = data;
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic start_run();
        @(negedge clk);
        run = 1'b1;
    endtask

    // Skips retires without a register write
    task automatic expect_retire(input word_t exp_pc, input reg_idx_t exp_rd,
                                 input word_t exp_data);
        int   n;
        logic found;
        found = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !found; n++) begin
            @(negedge clk);
            if (retire_valid && retire_we) begin
                found = 1'b1;
                check_word("retire_pc", retire_pc, exp_pc);
                check_reg("retire_rd", retire_rd, exp_rd);
                check_word("retire_data", retire_data, exp_data);
            end
        end
        if (!found) begin
            timeout_count++;
            $display("Timeout: no register write-back within %0d cycles (expected pc %h)",
                     WAIT_LIMIT, exp_pc);
        end
    endtask

    task automatic expect_halt(input word_t ecall_pc);
        int   n;
        logic found;
        found = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !found; n++) begin
            @(negedge clk);
            if (retire_valid && retire_pc == ecall_pc) begin
                found = 1'b1;
                check_flag("retire_we", retire_we, 1'b0);
            end
        end
        if (!found) begin
            timeout_count++;
            $display("Timeout: ECALL at pc %h never retired", ecall_pc);
        end else begin
            repeat (3) begin                         // Halt holds and nothing retires
                @(negedge clk);
                check_flag("halted", halted, 1'b1);
                check_flag("retire_valid", retire_valid, 1'b0);
            end
        end
    endtask

    //========================================
    // Case file interpreter
    //========================================
    initial begin
        int               fd;
        int               code;
        string            tag;
        logic [8*256-1:0] line_rest;
        word_t            addr;
        word_t            data;
        reg_idx_t         rd;
        logic             done;
        logic             bad;

        clk           = 1'b0;
        rst           = 1'b1;
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_wdata    = '0;
        error_count   = 0;
        timeout_count = 0;
        done          = 1'b0;
        bad           = 1'b0;

        fd = $fopen("testbench/rv32i_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the case file testbench/rv32i_cases.txt");
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;                        // End of file
            end else if (tag == "#") begin
                code = $fgets(line_rest, fd);
            end else if (tag == "C") begin
                reset_core();
            end else if (tag == "R") begin
                start_run();
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h", addr, data);
                if (code == 2)
                    load_word(addr, data);
                else
                    bad = 1'b1;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %d %h", addr, rd, data);
                if (code == 3)
                    expect_retire(addr, rd, data);
                else
                    bad = 1'b1;
            end else if (tag == "H") begin
                code = $fscanf(fd, "%h", addr);
                if (code == 1)
                    expect_halt(addr);
                else
                    bad = 1'b1;
            end else begin
                bad = 1'b1;
            end
            if (bad) begin
                error_count++;
                $display("Case file has a bad or incomplete record starting with %s", tag);
                done = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: hdl/rv32i_core.sv
//========================================
// Single-cycle RV32I core top level
// Load the program with run low, then raise run
//========================================
module rv32i_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                prog_we,
    input  logic [7:0]          prog_addr,
    input  rv32i_pkg::word_t    prog_wdata,
    output logic                halted,
    output logic                retire_valid,
    output rv32i_pkg::word_t    retire_pc,
    output logic                retire_we,
    output rv32i_pkg::reg_idx_t retire_rd,
    output rv32i_pkg::word_t    retire_data
);
    import rv32i_pkg::*;

    rv32i_instr_u instr;
    reg_idx_t     rs1_addr, rs2_addr;
    word_t        rs1_data, rs2_data, alu_a, alu_b, alu_y;
    word_t        mem_addr, load_data, csr_wdata, csr_rdata, mtvec, mepc, trap_pc;
    alu_op_e      alu_op;
    mem_size_e    mem_size;
    csr_op_e      csr_op;
    csr_addr_t    csr_addr;
    logic         mem_we, trap;

    // Retire outputs double as the write-back and fetch buses
    rv32i_ctrl u_ctrl (
        .clk, .rst, .run, .instr, .rs1_data, .rs2_data, .alu_y, .load_data,
        .csr_rdata, .mtvec, .mepc, .pc(retire_pc), .rs1_addr, .rs2_addr,
        .rd_addr(retire_rd), .rd_we(retire_we), .rd_wdata(retire_data),
        .alu_op, .alu_a, .alu_b, .mem_we, .mem_size, .mem_addr, .csr_op,
        .csr_addr, .csr_wdata, .trap, .trap_pc, .halted, .retire_valid
    );

    rv32i_alu u_alu (.alu_op, .a(alu_a), .b(alu_b), .y(alu_y));

    rv32i_regfile u_regfile (
        .clk, .rst, .rs1_addr, .rs2_addr, .rd_addr(retire_rd), .rd_we(retire_we),
        .rd_wdata(retire_data), .rs1_data, .rs2_data
    );

    rv32i_mem u_mem (
        .clk, .prog_we, .prog_addr, .prog_wdata, .pc(retire_pc), .instr,
        .mem_we, .mem_size, .mem_addr, .store_data(rs2_data), .load_data
    );

    rv32i_trap_csr u_trap_csr (
        .clk, .rst, .csr_op, .csr_addr, .csr_wdata, .trap, .trap_pc,
        .csr_rdata, .mtvec, .mepc
    );

endmodule

// File: hdl/rv32i_ctrl.sv
//========================================
// Decode, immediates, pc and halt state
// Steers the datapath for one instruction per executing cycle
//========================================
`include "rv32i_consts.svh"

module rv32i_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  rv32i_pkg::rv32i_instr_u instr,
    input  rv32i_pkg::word_t        rs1_data,
    input  rv32i_pkg::word_t        rs2_data,
    input  rv32i_pkg::word_t        alu_y,
    input  rv32i_pkg::word_t        load_data,
    input  rv32i_pkg::word_t        csr_rdata,
    input  rv32i_pkg::word_t        mtvec,
    input  rv32i_pkg::word_t        mepc,
    output rv32i_pkg::word_t        pc,
    output rv32i_pkg::reg_idx_t     rs1_addr,
    output rv32i_pkg::reg_idx_t     rs2_addr,
    output rv32i_pkg::reg_idx_t     rd_addr,
    output logic                    rd_we,
    output rv32i_pkg::word_t        rd_wdata,
    output rv32i_pkg::alu_op_e      alu_op,
    output rv32i_pkg::word_t        alu_a,
    output rv32i_pkg::word_t        alu_b,
    output logic                    mem_we,
    output rv32i_pkg::mem_size_e    mem_size,
    output rv32i_pkg::word_t        mem_addr,
    output rv32i_pkg::csr_op_e      csr_op,
    output rv32i_pkg::csr_addr_t    csr_addr,
    output rv32i_pkg::word_t        csr_wdata,
    output logic                    trap,
    output rv32i_pkg::word_t        trap_pc,
    output logic                    halted,
    output logic                    retire_valid
);
    import rv32i_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      pc_plus4, next_pc;
    alu_op_e    arith_op;
    logic       exec, wb_en, illegal, halt_req;

    assign opcode   = instr.r.opcode;
    assign funct3   = instr.r.funct3;
    assign funct7   = instr.r.funct7;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;
    assign rd_addr  = instr.r.rd;

    //========================================
    // Immediates
    //========================================
    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                    instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
    assign imm_j = {{12{instr.i.imm12[11]}}, instr.i.rs1, instr.i.funct3,
                    instr.i.imm12[0], instr.i.imm12[10:1], 1'b0};

    assign exec         = run & ~halted & ~rst;
    assign retire_valid = exec;
    assign pc_plus4     = pc + `RV32I_PC_STEP;
    assign mem_addr     = alu_y;                   // rs1 plus offset
    assign mem_size     = mem_size_e'(funct3);
    assign csr_addr     = instr.i.imm12;
    assign csr_wdata    = funct3[2] ? {27'b0, instr.r.rs1} : rs1_data;  // uimm forms
    assign trap         = exec & illegal;
    assign trap_pc      = pc;
    assign rd_we        = exec & wb_en & (rd_addr != 5'd0);
    assign mem_we       = exec & ~illegal & (opcode == `RV32I_OPC_STORE);

    // Shared by OP and OP-IMM with SUB in the register form only
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == `RV32I_OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    //========================================
    // Main decode
    //========================================
    always_comb begin
        alu_op   = ALU_ADD;
        alu_a    = rs1_data;
        alu_b    = imm_i;
        rd_wdata = alu_y;
        next_pc  = pc_plus4;
        wb_en    = 1'b0;
        illegal  = 1'b0;
        halt_req = 1'b0;
        csr_op   = CSR_NONE;
        case (opcode)
            `RV32I_OPC_LUI: begin
                alu_a = '0;
                alu_b = imm_u;
                wb_en = 1'b1;
            end
            `RV32I_OPC_AUIPC: begin
                alu_a = pc;
                alu_b = imm_u;
                wb_en = 1'b1;
            end
            `RV32I_OPC_JAL: begin
                rd_wdata = pc_plus4;
                wb_en    = 1'b1;
                next_pc  = pc + imm_j;
            end
            `RV32I_OPC_JALR: begin
                rd_wdata = pc_plus4;
                wb_en    = 1'b1;
                next_pc  = {alu_y[31:1], 1'b0};
            end
            `RV32I_OPC_BRANCH: begin
                alu_b = rs2_data;
                case (funct3[2:1])
                    2'b00:   alu_op = ALU_EQ;
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: illegal = 1'b1;
                endcase
                if (alu_y[0] ^ funct3[0])          // Odd funct3 inverts the compare
                    next_pc = pc + imm_b;
            end
            `RV32I_OPC_LOAD: begin
                rd_wdata = load_data;
                wb_en    = 1'b1;
                illegal  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            `RV32I_OPC_STORE: begin
                alu_b   = imm_s;
                illegal = funct3 > 3'b010;
            end
            `RV32I_OPC_OP_IMM: begin
                alu_op  = arith_op;
                wb_en   = 1'b1;
                illegal = (funct3 == 3'b001 && funct7 != 7'd0) ||
                          (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'd0);
            end
            `RV32I_OPC_OP: begin
                alu_op  = arith_op;
                alu_b   = rs2_data;
                wb_en   = 1'b1;
                illegal = ((funct7 & 7'b1011111) != 7'd0) ||
                          (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101);
            end
            `RV32I_OPC_MISC_MEM: begin
                // FENCE has nothing to order here
            end
            `RV32I_OPC_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    if (instr.i.rs1 != 5'd0 || instr.i.rd != 5'd0)
                        illegal = 1'b1;
                    else if (instr.i.imm12 == 12'h000 || instr.i.imm12 == 12'h001)
                        halt_req = 1'b1;                    // ECALL, EBREAK
                    else if (instr.i.imm12 == 12'h302)
                        next_pc = mepc + `RV32I_PC_STEP;    // MRET
                    else
                        illegal = 1'b1;
                end else if (funct3 == 3'b100) begin
                    illegal = 1'b1;
                end else begin
                    rd_wdata = csr_rdata;
                    wb_en    = 1'b1;
                    // Set or clear with a zero source leaves the CSR alone
                    if (!(funct3[1] && instr.r.rs1 == 5'd0))
                        csr_op = csr_op_e'(funct3[1:0]);
                end
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            next_pc = mtvec;
            wb_en   = 1'b0;
        end
        if (!exec)
            csr_op = CSR_NONE;
    end

    //========================================
    // pc and halt state
    //========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (exec) begin
            pc <= next_pc;
            if (halt_req)
                halted <= 1'b1;                // Held until the next reset
        end
    end

endmodule

// File: hdl/rv32i_trap_csr.sv
//========================================
// Machine CSRs and trap state
// Reads return the old value, trap update wins over a CSR write
//========================================
`include "rv32i_consts.svh"

module rv32i_trap_csr (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::csr_op_e   csr_op,
    input  rv32i_pkg::csr_addr_t csr_addr,
    input  rv32i_pkg::word_t     csr_wdata,
    input  logic                 trap,
    input  rv32i_pkg::word_t     trap_pc,
    output rv32i_pkg::word_t     csr_rdata,
    output rv32i_pkg::word_t     mtvec,
    output rv32i_pkg::word_t     mepc
);
    import rv32i_pkg::*;

    word_t mcause, mscratch;
    word_t new_val;

    always_comb begin
        case (csr_addr)
            `RV32I_CSR_MTVEC:    csr_rdata = mtvec;
            `RV32I_CSR_MEPC:     csr_rdata = mepc;
            `RV32I_CSR_MCAUSE:   csr_rdata = mcause;
            `RV32I_CSR_MSCRATCH: csr_rdata = mscratch;
            default:             csr_rdata = '0;    // Unknown CSRs read as zero
        endcase
        case (csr_op)
            CSR_SET:   new_val = csr_rdata | csr_wdata;
            CSR_CLEAR: new_val = csr_rdata & ~csr_wdata;
            default:   new_val = csr_wdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= `RV32I_MSCRATCH_RESET;
        end else begin
            if (csr_op != CSR_NONE) begin
                case (csr_addr)
                    `RV32I_CSR_MTVEC:    mtvec    <= new_val;
                    `RV32I_CSR_MEPC:     mepc     <= new_val;
                    `RV32I_CSR_MCAUSE:   mcause   <= new_val;
                    `RV32I_CSR_MSCRATCH: mscratch <= new_val;
                    default: ;
                endcase
            end
            if (trap) begin
                mepc   <= trap_pc;
                mcause <= `RV32I_MCAUSE_ILLEGAL;
            end
        end
    end

endmodule

// File: hdl/rv32i_mem.sv
//========================================
// Instruction memory with program-load port
// Byte-addressed data memory with store lanes and load extension
//========================================
`include "rv32i_consts.svh"

module rv32i_mem (
    input  logic                    clk,
    input  logic                    prog_we,
    input  logic [7:0]              prog_addr,
    input  rv32i_pkg::word_t        prog_wdata,
    input  rv32i_pkg::word_t        pc,
    output rv32i_pkg::rv32i_instr_u instr,
    input  logic                    mem_we,
    input  rv32i_pkg::mem_size_e    mem_size,
    input  rv32i_pkg::word_t        mem_addr,
    input  rv32i_pkg::word_t        store_data,
    output rv32i_pkg::word_t        load_data
);
    import rv32i_pkg::*;

    localparam int IMEM_AW = $clog2(`RV32I_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV32I_DMEM_BYTES);

    word_t      imem [`RV32I_IMEM_WORDS];
    logic [7:0] dmem [`RV32I_DMEM_BYTES];
    logic [DMEM_AW-1:0] a0, a1, a2, a3;
    logic [7:0]         b0, b1, b2, b3;

    assign instr = imem[pc[IMEM_AW+1:2]];

    // Lane addresses wrap inside the data memory
    assign a0 = mem_addr[DMEM_AW-1:0];
    assign a1 = a0 + 1'b1;
    assign a2 = a0 + 2'd2;
    assign a3 = a0 + 2'd3;
    assign b0 = dmem[a0];
    assign b1 = dmem[a1];
    assign b2 = dmem[a2];
    assign b3 = dmem[a3];

    always_comb begin
        case (mem_size)
            MEM_B:   load_data = {{24{b0[7]}}, b0};
            MEM_H:   load_data = {{16{b1[7]}}, b1, b0};
            MEM_BU:  load_data = {24'b0, b0};
            MEM_HU:  load_data = {16'b0, b1, b0};
            default: load_data = {b3, b2, b1, b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_wdata;
        if (mem_we) begin
            dmem[a0] <= store_data[7:0];
            if (mem_size != MEM_B)
                dmem[a1] <= store_data[15:8];
            if (mem_size == MEM_W) begin     // Upper half only for SW
                dmem[a2] <= store_data[23:16];
                dmem[a3] <= store_data[31:24];
            end
        end
    end

endmodule

// File: hdl/rv32i_regfile.sv
//========================================
// Integer register file, two reads and one write
//========================================
module rv32i_regfile (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::reg_idx_t rs1_addr,
    input  rv32i_pkg::reg_idx_t rs2_addr,
    input  rv32i_pkg::reg_idx_t rd_addr,
    input  logic                rd_we,
    input  rv32i_pkg::word_t    rd_wdata,
    output rv32i_pkg::word_t    rs1_data,
    output rv32i_pkg::word_t    rs2_data
);
    import rv32i_pkg::*;

    word_t regs [1:31];    // x0 has no storage

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < 32; r++)
                regs[r] <= '0;
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

endmodule

// File: hdl/rv32i_alu.sv
//========================================
// Combinational ALU for the RV32I core
// Compare results land in bit 0
//========================================
module rv32i_alu (
    input  rv32i_pkg::alu_op_e alu_op,
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    output rv32i_pkg::word_t   y
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'b0, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            ALU_EQ:   y = {31'b0, a == b};     // Branch equality
            default:  y = '0;
        endcase
    end

endmodule

// File: hdl/rv32i_pkg.sv
//========================================
// Types shared by the core and its testbench
//========================================
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_EQ
    } alu_op_e;

    // Same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_size_e;

    typedef enum logic [1:0] {
        CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR    // Matches funct3[1:0]
    } csr_op_e;

    //========================================
    // Instruction word views
    //========================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } rv32i_instr_u;

endpackage

// File: hdl/rv32i_consts.svh
//========================================
// Shared constants for the RV32I core
// Include in any RTL file that needs depths, opcodes or CSR numbers
//========================================
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

`define RV32I_IMEM_WORDS      256
`define RV32I_DMEM_BYTES      1024

// Major opcodes
`define RV32I_OPC_LUI         7'b0110111
`define RV32I_OPC_AUIPC       7'b0010111
`define RV32I_OPC_JAL         7'b1101111
`define RV32I_OPC_JALR        7'b1100111
`define RV32I_OPC_BRANCH      7'b1100011
`define RV32I_OPC_LOAD        7'b0000011
`define RV32I_OPC_STORE       7'b0100011
`define RV32I_OPC_OP_IMM      7'b0010011
`define RV32I_OPC_OP          7'b0110011
`define RV32I_OPC_MISC_MEM    7'b0001111
`define RV32I_OPC_SYSTEM      7'b1110011

`define RV32I_CSR_MTVEC       12'h305
`define RV32I_CSR_MEPC        12'h341
`define RV32I_CSR_MCAUSE      12'h342
`define RV32I_CSR_MSCRATCH    12'h340

`define RV32I_MSCRATCH_RESET  32'h1001
`define RV32I_MCAUSE_ILLEGAL  32'd2
`define RV32I_PC_STEP         32'd4

`endif
